// File: dv/tb_soc.sv
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

    localparam logic [31:0] nop         = 32'h0000_0013;          // addi x0, x0, 0
    localparam logic [63:0] handler     = 64'h0000_0000_0000_1100; // mtvec in the irq tests
    localparam int          prog_words  = 56;   // words loaded over all tests
    localparam int          cycle_limit = 2 * prog_words + 200;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [63:0] pc;
    logic        key_valid;
    logic [7:0]  key_data;
    logic [63:0] art_data;
    logic        art_strobe;
    logic        irq_ack;

    logic [31:0] imem [logic [63:0]];   // sparse program memory
    int          mem_version;           // bumped on every load, wakes the fetch model
    int          cycle_count;
    int          ack_count;
    int          strobe_count;
    logic [15:0] lfsr_state;

    soc_top uut (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .key_valid   (key_valid),
        .key_data    (key_data),
        .art_data    (art_data),
        .art_strobe  (art_strobe),
        .irq_ack     (irq_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // combinational fetch, holes read as nop
    always @(pc or mem_version) begin
        if (imem.exists(pc))
            instruction = imem[pc];
        else
            instruction = nop;
    end

    // pulse counters and watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (irq_ack)
            ack_count++;
        if (art_strobe)
            strobe_count++;
        if (cycle_count >= cycle_limit) begin
            $display("run passed the limit of %0d cycles", cycle_limit);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // 16 bit fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);   // one step per bit
            value      = {value[6:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // rv64 encoders
    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op_op_imm};
    endfunction

    function automatic logic [31:0] ld_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, op_load};
    endfunction

    function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] csrrw_word(input logic [4:0] rd, input logic [11:0] csr,
                                               input logic [4:0] rs1);
        return {csr, rs1, 3'b001, rd, op_system};
    endfunction

    task automatic put_word(input logic [63:0] addr, input logic [31:0] word);
        imem[addr] = word;
        mem_version++;
    endtask

    // reset goes low here, program gets loaded while the core is held
    task automatic start_program();
        @(posedge clk);
        reset     <= 1'b0;
        key_valid <= 1'b0;
        imem.delete();
        mem_version++;
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        ack_count    = 0;
        strobe_count = 0;
    endtask

    task automatic deliver_key(input logic [7:0] value);
        @(posedge clk);
        key_valid <= 1'b1;
        key_data  <= value;
        @(posedge clk);
        key_valid <= 1'b0;  // single cycle pulse
    endtask

    task automatic wait_strobe(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!art_strobe) begin
            n++;
            assert (n <= limit) else begin
                $display("no art_strobe within %0d cycles", limit);
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    // current cycle counts, mret can land together with a strobe
    task automatic wait_pc(input logic [63:0] target, input int limit);
        int n;
        n = 0;
        while (pc !== target) begin
            n++;
            assert (n <= limit) else begin
                $display("pc never reached %h within %0d cycles", target, limit);
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    // pc_before is pc in the cycle the trap was decided
    task automatic wait_ack(input int limit, output logic [63:0] pc_before);
        int n;
        n         = 0;
        pc_before = pc;
        @(negedge clk);
        while (!irq_ack) begin
            n++;
            assert (n <= limit) else begin
                $display("no irq_ack within %0d cycles of the key", limit);
                stop_run();
            end
            pc_before = pc;
            @(negedge clk);
        end
    endtask

    // x1 key_base, x2 art_base, mtvec and meie set, mie only when enabled
    task automatic load_trap_setup(input logic enable);
        put_word(ram_base,      lui_word(1, 20'h00002));
        put_word(ram_base + 4,  lui_word(2, 20'h00003));
        put_word(ram_base + 8,  lui_word(3, 20'h00001));
        put_word(ram_base + 12, addi_word(3, 3, 12'h100));      // 0x1100
        put_word(ram_base + 16, csrrw_word(0, csr_mtvec, 3));
        put_word(ram_base + 20, addi_word(4, 0, 12'h7ff));
        put_word(ram_base + 24, addi_word(4, 4, 12'h001));      // bit 11
        put_word(ram_base + 28, csrrw_word(0, csr_mie, 4));
        if (enable) begin
            put_word(ram_base + 32, addi_word(7, 0, 12'h008));  // mstatus.mie
            put_word(ram_base + 36, csrrw_word(0, csr_mstatus, 7));
        end
    endtask

    task automatic check_reset_state();
        start_program();
        @(negedge clk);
        check_value("pc", pc, ram_base);
        check_value("art_strobe", art_strobe, 64'd0);
        check_value("irq_ack", irq_ack, 64'd0);
        release_reset();
        check_value("pc", pc, ram_base);
    endtask

    task automatic build_constant();
        logic [63:0] expected;
        start_program();
        put_word(ram_base,      lui_word(2, 20'h00003));
        put_word(ram_base + 4,  lui_word(5, 20'h12345));
        put_word(ram_base + 8,  addi_word(5, 5, 12'hff8));     // -8
        put_word(ram_base + 12, sd_word(5, 2, 12'h000));
        expected = 64'h0000_0000_1234_5000 - 64'd8;
        release_reset();
        wait_strobe(20);
        check_value("art_data", art_data, expected);
        @(negedge clk);
        check_value("art_strobe", art_strobe, 64'd0);         // single pulse
        repeat (2) @(negedge clk);
        check_value("strobe_count", strobe_count, 64'd1);
    endtask

    task automatic echo_key();
        logic [7:0] key;
        start_program();
        put_word(ram_base,      lui_word(1, 20'h00002));
        put_word(ram_base + 4,  lui_word(2, 20'h00003));
        put_word(ram_base + 8,  nop);
        put_word(ram_base + 12, nop);   // key lands before the load
        put_word(ram_base + 16, ld_word(6, 1, 12'h000));
        put_word(ram_base + 20, sd_word(6, 2, 12'h000));
        release_reset();
        key = random_byte();
        deliver_key(key);
        wait_strobe(20);
        check_value("art_data", art_data, {56'd0, key});
    endtask

    task automatic irq_taken();
        logic [7:0]  key;
        logic [63:0] pc_before;
        logic [63:0] resume;
        start_program();
        load_trap_setup(1'b1);
        put_word(handler,     ld_word(6, 1, 12'h000));   // read clears pending
        put_word(handler + 4, sd_word(6, 2, 12'h000));
        put_word(handler + 8, mret_word);
        release_reset();
        wait_pc(ram_base + 64'd48, 20);
        key = random_byte();
        deliver_key(key);
        wait_ack(3, pc_before);
        check_value("pc", pc, handler);
        resume = pc_before - 64'd4;     // squashed word runs again
        wait_strobe(20);
        check_value("art_data", art_data, {56'd0, key});
        wait_pc(resume, 20);
        repeat (4) @(negedge clk);
        check_value("ack_count", ack_count, 64'd1);
    endtask

    task automatic irq_masked();
        logic [63:0] last_pc;
        start_program();
        load_trap_setup(1'b0);
        release_reset();
        wait_pc(ram_base + 64'd36, 20);
        deliver_key(random_byte());
        @(negedge clk);
        last_pc = pc;
        repeat (8) begin
            @(negedge clk);
            check_value("irq_ack", irq_ack, 64'd0);
            check_value("pc", pc, last_pc + 64'd4);
            last_pc = pc;
        end
        check_value("ack_count", ack_count, 64'd0);
    endtask

    task automatic irq_not_nested();
        logic [63:0] pc_before;
        logic [63:0] resume;
        start_program();
        load_trap_setup(1'b1);
        put_word(ram_base + 40, addi_word(9, 0, 12'h080));     // mpie only
        put_word(handler,       ld_word(6, 1, 12'h000));
        put_word(handler + 4,   csrrw_word(8, csr_mstatus, 9)); // old mstatus to x8
        put_word(handler + 8,   sd_word(8, 2, 12'h000));
        for (int i = 3; i < 13; i++)
            put_word(handler + 4 * i, nop);     // room for a second key
        put_word(handler + 52,  mret_word);
        release_reset();
        wait_pc(ram_base + 64'd48, 20);
        deliver_key(random_byte());
        wait_ack(3, pc_before);
        check_value("pc", pc, handler);
        resume = pc_before - 64'd4;
        wait_strobe(20);
        check_value("art_data", art_data, 64'h80);    // mpie set, mie clear
        deliver_key(random_byte());
        wait_pc(resume, 30);
        check_value("ack_count", ack_count, 64'd1);   // held off inside handler
        wait_ack(3, pc_before);
        check_value("pc", pc, handler);
        check_value("mepc", pc_before - 64'd4, resume);
        wait_strobe(20);
        wait_pc(resume, 30);
        repeat (4) @(negedge clk);
        check_value("ack_count", ack_count, 64'd2);
    endtask

    initial begin
        reset        = 1'b0;
        key_valid    = 1'b0;
        key_data     = 8'h00;
        instruction  = nop;
        mem_version  = 0;
        cycle_count  = 0;
        ack_count    = 0;
        strobe_count = 0;
        lfsr_state   = 16'd5055;
        check_reset_state();
        build_constant();
        echo_key();
        irq_taken();
        irq_masked();
        irq_not_nested();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: project.f
verilog/soc_pkg.sv
verilog/key_port.sv
verilog/art_port.sv
verilog/bus_decoder.sv
verilog/machine_csr.sv
verilog/rv_core.sv
verilog/soc_top.sv
dv/tb_soc.sv

// File: verilog/art_port.sv
`timescale 1ns/1ps

module art_port import soc_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            we,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] art_data,
    output logic            art_strobe
);

    // display starts blank
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            art_data   <= '0;
            art_strobe <= 1'b0;
        end else begin
            art_strobe <= we;   // one pulse per store
            if (we)
                art_data <= wdata;
        end
    end

endmodule

// File: verilog/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import soc_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  bus_req_t        bus_req,
    output bus_rsp_t        bus_rsp,
    output logic            key_rd,
    input  logic [7:0]      key_rdata,
    output logic            art_we,
    output logic [xlen-1:0] art_wdata
);
    logic            key_sel;
    logic            art_sel;
    logic            rsp_hit;
    logic [xlen-1:0] rsp_rdata;

    // page compare only
    assign key_sel = (bus_req.addr & periph_mask) == (key_base & periph_mask);
    assign art_sel = (bus_req.addr & periph_mask) == (art_base & periph_mask);

    assign key_rd    = bus_req.re && key_sel;   // clears key full
    assign art_we    = bus_req.we && art_sel;
    assign art_wdata = bus_req.wdata;

    assign bus_rsp = '{rdata: rsp_rdata, hit: rsp_hit};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            rsp_hit <= 1'b0;
        else
            rsp_hit <= (bus_req.re || bus_req.we) && (key_sel || art_sel);
    end

    // read data one cycle after re
    always_ff @(posedge clk) begin
        if (bus_req.re && key_sel)
            rsp_rdata <= {56'd0, key_rdata};   // zero extend
        else
            rsp_rdata <= '0;    // art is write only
    end

endmodule

// File: verilog/key_port.sv
`timescale 1ns/1ps

module key_port (
    input  logic       clk,
    input  logic       reset,
    input  logic       key_valid,
    input  logic [7:0] key_data,
    input  logic       rd,
    output logic [7:0] rdata,
    output logic       irq
);
    logic [7:0] held;   // last key byte
    logic       full;

    assign rdata = held;
    assign irq   = full;    // level, stays until read

    // new key wins over a read in the same cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            full <= 1'b0;
        else if (key_valid)
            full <= 1'b1;
        else if (rd)
            full <= 1'b0;
    end

    // overwrite on every key
    always_ff @(posedge clk) begin
        if (key_valid)
            held <= key_data;
    end

endmodule

// File: verilog/machine_csr.sv
`timescale 1ns/1ps

module machine_csr import soc_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  csr_req_t        csr_req,
    output logic [xlen-1:0] csr_rdata,
    input  logic            ext_irq,
    input  logic            insn_boundary,
    input  logic [xlen-1:0] epc,
    output trap_t           trap,
    output logic            irq_ack
);
    logic            mstatus_mie;   // global enable
    logic            mstatus_mpie;  // mie before trap
    logic            mie_meie;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic            take;

    // meip follows the key port directly
    assign take = mstatus_mie && mie_meie && ext_irq && insn_boundary;

    // direct mode only, low bits of mtvec ignored
    assign trap.take   = take;
    assign trap.target = take ? {mtvec[xlen-1:2], 2'b00} : mepc;

    // old value back to the core, same cycle
    always_comb begin
        case (csr_req.num)
            csr_mstatus: csr_rdata = {56'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
            csr_mie:     csr_rdata = {52'd0, mie_meie, 11'd0};
            csr_mip:     csr_rdata = {52'd0, ext_irq, 11'd0};
            csr_mtvec:   csr_rdata = mtvec;
            csr_mepc:    csr_rdata = mepc;
            csr_mcause:  csr_rdata = mcause;
            default:     csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_meie     <= 1'b0;
            mtvec        <= '0;
            mepc         <= '0;
            mcause       <= '0;
            irq_ack      <= 1'b0;
        end else begin
            irq_ack <= take;    // high while pc shows mtvec
            if (take) begin
                mepc         <= epc;
                mcause       <= cause_mext;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;   // no nesting
            end else if (csr_req.mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end else if (csr_req.valid) begin
                case (csr_req.num)
                    csr_mstatus: begin
                        mstatus_mie  <= csr_req.wdata[3];
                        mstatus_mpie <= csr_req.wdata[7];
                    end
                    csr_mie:    mie_meie <= csr_req.wdata[11];
                    csr_mtvec:  mtvec    <= csr_req.wdata;
                    csr_mepc:   mepc     <= csr_req.wdata;
                    csr_mcause: mcause   <= csr_req.wdata;
                    default: ;  // mip read only
                endcase
            end
        end
    end

    // core must squash an mret when a trap wins the boundary
    a_take_mret: assert property (@(posedge clk) disable iff (!reset)
        !(trap.take && csr_req.mret));

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core import soc_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [ilen-1:0] instruction,
    output logic [xlen-1:0] pc,
    output bus_req_t        bus_req,
    input  bus_rsp_t        bus_rsp,
    output csr_req_t        csr_req,
    input  logic [xlen-1:0] csr_rdata,
    input  trap_t           trap,
    output logic            insn_boundary,
    output logic [xlen-1:0] epc
);
    logic [ilen-1:0] ir;        // word in execute
    logic [xlen-1:0] ir_pc;     // fetch address of ir
    logic            bubble;    // squash ir after a redirect
    logic            ld_step;   // ld waiting for its re cycle
    logic            ld_wb;     // ld data on bus_rsp now
    logic [4:0]      ld_rd;
    logic [xlen-1:0] rf [32];   // x0 never read from here

    // registered bus request
    logic            req_re;
    logic            req_we;
    logic [xlen-1:0] req_addr;
    logic [xlen-1:0] req_wdata;

    // decode
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] ld_data;
    logic            exec;
    logic            is_lui;
    logic            is_addi;
    logic            is_ld;
    logic            is_sd;
    logic            is_csrrw;
    logic            is_mret;
    logic            redirect;

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign rd     = ir[11:7];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign imm_i  = {{52{ir[31]}}, ir[31:20]};
    assign imm_s  = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u  = {{32{ir[31]}}, ir[31:12], 12'd0};

    // register read with bypass of the load landing this cycle
    assign rs1_val = (rs1 == 5'd0)           ? '0      :
                     (ld_wb && ld_rd == rs1) ? ld_data : rf[rs1];
    assign rs2_val = (rs2 == 5'd0)           ? '0      :
                     (ld_wb && ld_rd == rs2) ? ld_data : rf[rs2];
    assign ld_data = bus_rsp.hit ? bus_rsp.rdata : '0;  // unmapped reads as zero

    assign is_lui   = (opcode == op_lui);
    assign is_addi  = (opcode == op_op_imm) && (funct3 == 3'b000);
    assign is_ld    = (opcode == op_load)   && (funct3 == 3'b011);
    assign is_sd    = (opcode == op_store)  && (funct3 == 3'b011);
    assign is_csrrw = (opcode == op_system) && (funct3 == 3'b001);
    assign is_mret  = (ir == mret_word);

    // trap squashes the word in ir, it reruns after mret
    assign insn_boundary = !bubble && !ld_step;
    assign exec          = insn_boundary && !trap.take;
    assign redirect      = trap.take || (exec && is_mret);
    assign epc           = ir_pc;

    assign csr_req = '{valid: exec && is_csrrw, num: ir[31:20], wdata: rs1_val,
                       mret: exec && is_mret};
    assign bus_req = '{addr: req_addr, wdata: req_wdata, we: req_we, re: req_re};

    // fetch
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir    <= nop_word;
            ir_pc <= ram_base;
        end else begin
            ir    <= instruction;
            ir_pc <= pc;
        end
    end

    // pc and sequencing
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc      <= ram_base;
            bubble  <= 1'b0;
            ld_step <= 1'b0;
            ld_wb   <= 1'b0;
            req_re  <= 1'b0;
            req_we  <= 1'b0;
        end else begin
            pc      <= pc + 64'd4;
            bubble  <= 1'b0;
            ld_step <= 1'b0;
            ld_wb   <= ld_step;     // rdata lands one cycle after re
            req_re  <= 1'b0;
            req_we  <= 1'b0;
            if (redirect) begin
                pc     <= trap.target;  // mtvec or mepc
                bubble <= 1'b1;
            end else if (exec && is_ld) begin
                pc      <= pc;          // refetch the next word
                ld_step <= 1'b1;
                req_re  <= 1'b1;
            end else if (exec && is_sd) begin
                req_we <= 1'b1;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (exec && is_ld) begin
            req_addr <= rs1_val + imm_i;
            ld_rd    <= rd;
        end else if (exec && is_sd) begin
            req_addr  <= rs1_val + imm_s;
            req_wdata <= rs2_val;
        end
    end

    // register file, later instruction wins on a shared rd
    always_ff @(posedge clk) begin
        if (ld_wb && ld_rd != 5'd0)
            rf[ld_rd] <= ld_data;
        if (exec && rd != 5'd0) begin
            if (is_lui)
                rf[rd] <= imm_u;
            else if (is_addi)
                rf[rd] <= rs1_val + imm_i;
            else if (is_csrrw)
                rf[rd] <= csr_rdata;    // old csr value
        end
    end

    a_re_we_excl: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req.re && bus_req.we));

    // squashed word must not reach the bus
    a_no_req_bubble: assert property (@(posedge clk) disable iff (!reset)
        bubble |=> !(bus_req.re || bus_req.we));

endmodule

// File: verilog/soc_pkg.sv
package soc_pkg;

    // widths
    localparam int xlen = 64;
    localparam int ilen = 32;

    // address map
    localparam logic [xlen-1:0] ram_base    = 64'h0000_0000_0000_1000;  // reset pc
    localparam logic [xlen-1:0] key_base    = 64'h0000_0000_0000_2000;
    localparam logic [xlen-1:0] art_base    = 64'h0000_0000_0000_3000;
    localparam logic [xlen-1:0] periph_mask = ~64'h0000_0000_0000_0fff;  // 4 KiB pages

    // machine csr numbers
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mie     = 12'h304;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;
    localparam logic [11:0] csr_mip     = 12'h344;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [ilen-1:0] mret_word  = 32'h3020_0073;
    localparam logic [ilen-1:0] nop_word   = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [xlen-1:0] cause_mext = {1'b1, 59'd0, 4'd11};  // interrupt, code 11

    // core to peripherals
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            we;
        logic            re;
    } bus_req_t;

    // peripherals to core, one cycle after the request
    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            hit;   // address matched a port
    } bus_rsp_t;

    typedef struct packed {
        logic            valid; // csrrw this cycle
        logic [11:0]     num;
        logic [xlen-1:0] wdata;
        logic            mret;
    } csr_req_t;

    // pc redirect from the csr block
    typedef struct packed {
        logic            take;
        logic [xlen-1:0] target;
    } trap_t;

endpackage

// File: verilog/soc_top.sv
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [ilen-1:0] instruction,
    output logic [xlen-1:0] pc,
    input  logic            key_valid,
    input  logic [7:0]      key_data,
    output logic [xlen-1:0] art_data,
    output logic            art_strobe,
    output logic            irq_ack
);
    bus_req_t        core_req;
    bus_rsp_t        core_rsp;
    csr_req_t        csr_req;
    trap_t           trap;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] epc;
    logic            insn_boundary;
    logic            key_rd;
    logic [7:0]      key_rdata;
    logic            key_irq;       // meip source
    logic            art_we;
    logic [xlen-1:0] art_wdata;

    rv_core u_core (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .pc            (pc),
        .bus_req       (core_req),
        .bus_rsp       (core_rsp),
        .csr_req       (csr_req),
        .csr_rdata     (csr_rdata),
        .trap          (trap),
        .insn_boundary (insn_boundary),
        .epc           (epc)
    );

    machine_csr u_csr (
        .clk           (clk),
        .reset         (reset),
        .csr_req       (csr_req),
        .csr_rdata     (csr_rdata),
        .ext_irq       (key_irq),
        .insn_boundary (insn_boundary),
        .epc           (epc),
        .trap          (trap),
        .irq_ack       (irq_ack)
    );

    bus_decoder u_dec (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (core_req),
        .bus_rsp   (core_rsp),
        .key_rd    (key_rd),
        .key_rdata (key_rdata),
        .art_we    (art_we),
        .art_wdata (art_wdata)
    );

    key_port u_key (
        .clk       (clk),
        .reset     (reset),
        .key_valid (key_valid),
        .key_data  (key_data),
        .rd        (key_rd),
        .rdata     (key_rdata),
        .irq       (key_irq)
    );

    art_port u_art (
        .clk        (clk),
        .reset      (reset),
        .we         (art_we),
        .wdata      (art_wdata),
        .art_data   (art_data),
        .art_strobe (art_strobe)
    );

endmodule
